/* common/calc_defs.svh */
// Width and step-count macros for the keypad calculator
`ifndef CALC_DEFS_SVH
`define CALC_DEFS_SVH

// Operand and result word
`define CALC_WIDTH 16

// Key code bus
`define CALC_KEY_WIDTH 5

// One multiplier iteration per operand bit
`define CALC_MUL_STEPS 16

`endif

/* common/calc_pkg.sv */
// Key code, operator and control state enums for the calculator
`include "calc_defs.svh"

package calc_pkg;

    // Codes 15 to 31 are legal on the bus but carry no meaning
    typedef enum logic [`CALC_KEY_WIDTH-1:0] {
        KEY_0     = 5'd0,
        KEY_1     = 5'd1,
        KEY_2     = 5'd2,
        KEY_3     = 5'd3,
        KEY_4     = 5'd4,
        KEY_5     = 5'd5,
        KEY_6     = 5'd6,
        KEY_7     = 5'd7,
        KEY_8     = 5'd8,
        KEY_9     = 5'd9,
        KEY_ADD   = 5'd10,
        KEY_SUB   = 5'd11,
        KEY_MUL   = 5'd12,
        KEY_EQUAL = 5'd13,
        KEY_CLEAR = 5'd14
    } key_code_t;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_MUL
    } calc_op_t;

    typedef enum logic [2:0] {
        ENTER_A,
        ENTER_B,
        START_UNIT,
        WAIT_UNIT,
        SHOW
    } calc_state_t;

endpackage

/* common/arith_if.sv */
// Operand, start/done and result bus between control, operand store and one arithmetic unit
`timescale 1ns/1ps
`include "calc_defs.svh"

interface arith_if;

    logic [`CALC_WIDTH-1:0] a;
    logic [`CALC_WIDTH-1:0] b;
    logic                   start;
    logic                   sub;
    logic                   done;
    logic [`CALC_WIDTH-1:0] result;

    // Controller of the add/sub unit, also takes the sum when done
    modport ctrl (
        output start,
        output sub,
        input  done,
        input  result
    );

    // Operand registers
    modport src (
        output a,
        output b
    );

    modport unit (
        input  a,
        input  b,
        input  start,
        input  sub,
        output done,
        output result
    );

    // Result taker, which also launches a unit that has no sub input
    modport sink (
        output start,
        input  done,
        input  result
    );

endinterface

/* arith/step_counter.sv */
// Loadable down-counter pacing the multiplier steps, with last-step flag
`timescale 1ns/1ps
`include "calc_defs.svh"

module step_counter (
    input  logic clk,
    input  logic nRST,
    input  logic load,
    output logic busy,
    output logic last
);

    localparam int CNT_W = $clog2(`CALC_MUL_STEPS + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (load) begin
            count <= CNT_W'(`CALC_MUL_STEPS);
        end else if (busy) begin
            count <= count - 1'b1;
        end
    end

    assign busy = (count != '0);
    assign last = (count == CNT_W'(1));

endmodule

/* arith/add_sub_unit.sv */
// Registered 16-bit adder/subtractor with a one-cycle done pulse
`timescale 1ns/1ps
`include "calc_defs.svh"

module add_sub_unit (
    input  logic  clk,
    input  logic  nRST,
    arith_if.unit bus
);

    logic [`CALC_WIDTH-1:0] sum;
    logic [`CALC_WIDTH-1:0] operand_b;

    // Subtract as a plus inverted b plus one
    assign operand_b = bus.sub ? ~bus.b : bus.b;
    assign sum       = bus.a + operand_b + {{(`CALC_WIDTH - 1){1'b0}}, bus.sub};

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            bus.done <= 1'b0;
        end else begin
            bus.done <= bus.start;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.start) begin
            bus.result <= sum;
        end
    end

endmodule

/* arith/shift_add_multiplier.sv */
// Sequential shift-and-add multiplier returning the low 16 bits of the product
`timescale 1ns/1ps
`include "calc_defs.svh"

module shift_add_multiplier (
    input  logic  clk,
    input  logic  nRST,
    arith_if.unit bus
);

    logic [`CALC_WIDTH-1:0] mcand;
    logic [`CALC_WIDTH-1:0] mplier;
    logic [`CALC_WIDTH-1:0] acc;
    logic [`CALC_WIDTH-1:0] addend;
    logic                   busy;
    logic                   last;

    step_counter u_steps (
        .clk  (clk),
        .nRST (nRST),
        .load (bus.start),
        .busy (busy),
        .last (last)
    );

    assign addend = mplier[0] ? mcand : '0;

    // Bits shifted past the top are not needed for a 16-bit product
    always_ff @(posedge clk) begin
        if (bus.start) begin
            mcand  <= bus.a;
            mplier <= bus.b;
            acc    <= '0;
        end else if (busy) begin
            acc    <= acc + addend;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Final add lands on the edge that ends the last step
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            bus.done <= 1'b0;
        end else begin
            bus.done <= last;
        end
    end

    assign bus.result = acc;

endmodule

/* verilog/operand_entry.sv */
// Operand A and B registers with decimal digit accumulation and clear
`timescale 1ns/1ps
`include "calc_defs.svh"

module operand_entry (
    input  logic       clk,
    input  logic       nRST,
    input  logic       digit_en,
    input  logic [3:0] digit,
    input  logic       sel_b,
    input  logic       clear,
    arith_if.src       add_bus,
    arith_if.src       mul_bus
);

    logic [`CALC_WIDTH-1:0] op_a;
    logic [`CALC_WIDTH-1:0] op_b;
    logic [`CALC_WIDTH-1:0] acc_src;
    logic [`CALC_WIDTH-1:0] acc_next;

    assign acc_src = sel_b ? op_b : op_a;

    // Ten times as eight plus two, high bits fall off
    assign acc_next = (acc_src << 3) + (acc_src << 1)
                    + {{(`CALC_WIDTH - 4){1'b0}}, digit};

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            op_a <= '0;
            op_b <= '0;
        end else if (clear) begin
            op_a <= '0;
            op_b <= '0;
        end else if (digit_en) begin
            if (sel_b) begin
                op_b <= acc_next;
            end else begin
                op_a <= acc_next;
            end
        end
    end

    // Same operands feed both units
    assign add_bus.a = op_a;
    assign add_bus.b = op_b;
    assign mul_bus.a = op_a;
    assign mul_bus.b = op_b;

endmodule

/* verilog/calc_fsm.sv */
// Control FSM: key acceptance and decode, operator latch, unit start and result handshake
`timescale 1ns/1ps
`include "calc_defs.svh"

module calc_fsm
    import calc_pkg::*;
(
    input  logic                       clk,
    input  logic                       nRST,
    input  logic                       key_valid,
    input  logic [`CALC_KEY_WIDTH-1:0] key_code,
    output logic                       key_ready,
    output logic                       result_valid,
    output logic [`CALC_WIDTH-1:0]     result,
    input  logic                       result_ready,
    output logic                       digit_en,
    output logic [3:0]                 digit,
    output logic                       sel_b,
    output logic                       clear,
    arith_if.ctrl                      add_bus,
    arith_if.sink                      mul_bus
);

    calc_state_t            state;
    calc_state_t            next_state;
    calc_op_t               op;
    calc_op_t               key_op;
    key_code_t              key_q;
    logic                   key_pend;
    logic                   key_fire;
    logic                   is_digit;
    logic                   is_oper;
    logic                   unit_done;
    logic [`CALC_WIDTH-1:0] unit_result;
    logic [`CALC_WIDTH-1:0] result_q;

    // One key in flight at a time
    assign key_ready = ((state == ENTER_A) || (state == ENTER_B)) && !key_pend;
    assign key_fire  = key_valid && key_ready;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            key_pend <= 1'b0;
        end else begin
            key_pend <= key_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (key_fire) begin
            key_q <= key_code_t'(key_code);
        end
    end

    // Decode of the held key
    assign is_digit = (key_q <= KEY_9);
    assign is_oper  = (key_q == KEY_ADD) || (key_q == KEY_SUB) || (key_q == KEY_MUL);

    always_comb begin
        case (key_q)
            KEY_SUB: key_op = OP_SUB;
            KEY_MUL: key_op = OP_MUL;
            default: key_op = OP_ADD;
        endcase
    end

    assign digit_en = key_pend && is_digit;
    assign digit    = 4'(key_q);
    assign sel_b    = (state == ENTER_B);
    // Operands empty on clear key and on result hand-off
    assign clear    = (key_pend && (key_q == KEY_CLEAR)) || ((state == SHOW) && result_ready);

    always_comb begin
        next_state = state;
        case (state)
            ENTER_A, ENTER_B: begin
                if (key_pend) begin
                    if (key_q == KEY_CLEAR) begin
                        next_state = ENTER_A;
                    end else if (is_oper) begin
                        next_state = ENTER_B;
                    end else if ((key_q == KEY_EQUAL) && (state == ENTER_B)) begin
                        next_state = START_UNIT;
                    end
                end
            end
            START_UNIT: next_state = WAIT_UNIT;
            WAIT_UNIT: begin
                if (unit_done) begin
                    next_state = SHOW;
                end
            end
            SHOW: begin
                if (result_ready) begin
                    next_state = ENTER_A;
                end
            end
            default: next_state = ENTER_A;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state <= ENTER_A;
            op    <= OP_ADD;
        end else begin
            state <= next_state;
            if (key_pend && is_oper) begin
                op <= key_op;
            end
        end
    end

    // Unit launch and completion
    assign add_bus.start = (state == START_UNIT) && (op != OP_MUL);
    assign add_bus.sub   = (op == OP_SUB);
    assign mul_bus.start = (state == START_UNIT) && (op == OP_MUL);

    assign unit_done   = (op == OP_MUL) ? mul_bus.done : add_bus.done;
    assign unit_result = (op == OP_MUL) ? mul_bus.result : add_bus.result;

    always_ff @(posedge clk) begin
        if ((state == WAIT_UNIT) && unit_done) begin
            result_q <= unit_result;
        end
    end

    assign result_valid = (state == SHOW);
    assign result       = result_q;

endmodule

/* verilog/calc_top.sv */
// Calculator top level: control FSM, operand store, add/sub unit and multiplier
`timescale 1ns/1ps
`include "calc_defs.svh"

module calc_top (
    input  logic                       clk,
    input  logic                       nRST,
    input  logic                       key_valid,
    input  logic [`CALC_KEY_WIDTH-1:0] key_code,
    output logic                       key_ready,
    output logic                       result_valid,
    output logic [`CALC_WIDTH-1:0]     result,
    input  logic                       result_ready
);

    logic       digit_en;
    logic [3:0] digit;
    logic       sel_b;
    logic       clear;

    arith_if add_bus ();
    arith_if mul_bus ();

    calc_fsm u_fsm (
        .clk          (clk),
        .nRST         (nRST),
        .key_valid    (key_valid),
        .key_code     (key_code),
        .key_ready    (key_ready),
        .result_valid (result_valid),
        .result       (result),
        .result_ready (result_ready),
        .digit_en     (digit_en),
        .digit        (digit),
        .sel_b        (sel_b),
        .clear        (clear),
        .add_bus      (add_bus),
        .mul_bus      (mul_bus)
    );

    operand_entry u_operands (
        .clk      (clk),
        .nRST     (nRST),
        .digit_en (digit_en),
        .digit    (digit),
        .sel_b    (sel_b),
        .clear    (clear),
        .add_bus  (add_bus),
        .mul_bus  (mul_bus)
    );

    add_sub_unit u_add_sub (
        .clk  (clk),
        .nRST (nRST),
        .bus  (add_bus)
    );

    shift_add_multiplier u_mul (
        .clk  (clk),
        .nRST (nRST),
        .bus  (mul_bus)
    );

endmodule

/* testbench/calc_vectors.svh */
// Calculator test vectors: key strings, expected results and result hold flags
`ifndef CALC_VECTORS_SVH
`define CALC_VECTORS_SVH

// Columns: test name, key string, expected result, hold result_ready low
// Keys are digits, + - * = for operators, C for clear, ? for an unused code
task automatic load_vectors();
    add_vector("add_multi_digit",    "1234+4321=",   5555,  1'b0);
    add_vector("add_wrap",           "65535+1=",     0,     1'b0);
    add_vector("sub_wrap",           "5-7=",         65534, 1'b0);
    add_vector("sub_below_zero",     "0-1=",         65535, 1'b0);
    add_vector("op_replaced_sub",    "12*-5=",       7,     1'b0);
    add_vector("op_replaced_mul",    "6+*4=",        24,    1'b0);
    add_vector("mul_wrap",           "300*300=",     24464, 1'b0);
    add_vector("mul_small",          "255*255=",     65025, 1'b0);
    // 123456 enters as 57920
    add_vector("long_operand",       "123456*3=",    42688, 1'b0);
    add_vector("clear_then_equal",   "9C=2+3=",      5,     1'b0);
    add_vector("clear_in_b",         "4+5C6*7=",     42,    1'b0);
    add_vector("unused_codes",       "7?+2?=",       9,     1'b0);
    add_vector("stall_mul",          "250*4=",       1000,  1'b1);
    add_vector("after_stall_sub",    "8-3=",         5,     1'b0);
    add_vector("stall_add",          "40000+30000=", 4464,  1'b1);
    add_vector("after_stall_mul",    "2*21=",        42,    1'b0);
endtask

`endif

/* testbench/calc_tb.sv */
// Testbench: clock, reset, table-driven key stimulus, result handshake, checks and report
`timescale 1ns/1ps
`include "calc_defs.svh"

module calc_tb;

    localparam int WAIT_LIMIT = 200;

    logic                       clk;
    logic                       nRST;
    logic                       key_valid;
    logic [`CALC_KEY_WIDTH-1:0] key_code;
    logic                       key_ready;
    logic                       result_valid;
    logic [`CALC_WIDTH-1:0]     result;
    logic                       result_ready;

    string       vec_name[$];
    string       vec_keys[$];
    int          vec_exp[$];
    bit          vec_hold[$];
    int          error_count;
    int          errs_before;
    int          pass_count;
    int          fail_count;
    bit          timed_out;
    int          seed;
    int unsigned rnd;

    calc_top dut0 (
        .clk          (clk),
        .nRST         (nRST),
        .key_valid    (key_valid),
        .key_code     (key_code),
        .key_ready    (key_ready),
        .result_valid (result_valid),
        .result       (result),
        .result_ready (result_ready)
    );

    always #10 clk = ~clk;

    task automatic add_vector(input string name, input string keys, input int exp_val,
                              input bit hold);
        vec_name.push_back(name);
        vec_keys.push_back(keys);
        vec_exp.push_back(exp_val);
        vec_hold.push_back(hold);
    endtask

    `include "calc_vectors.svh"

    function automatic logic [`CALC_KEY_WIDTH-1:0] key_of(input byte c);
        case (c)
            "+": return 5'd10;
            "-": return 5'd11;
            "*": return 5'd12;
            "=": return 5'd13;
            "C": return 5'd14;
            "?": return 5'd20;
            default: return 5'(c - "0");
        endcase
    endfunction

    task automatic check_value(input string sig, input logic [31:0] got,
                               input logic [31:0] exp_val);
        if (got !== exp_val) begin
            $display("[FAIL] %0t ns %s: got %0d, expected %0d", $time, sig, got, exp_val);
            error_count++;
        end
    endtask

    // Polls key_ready or result_valid on falling edges
    task automatic wait_ready(input bit for_result);
        int n;
        n = 0;
        @(negedge clk);
        while (!(for_result ? result_valid : key_ready) && (n < WAIT_LIMIT)) begin
            @(negedge clk);
            n++;
        end
        if (!(for_result ? result_valid : key_ready)) begin
            $display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT,
                     for_result ? "result_valid" : "key_ready");
            timed_out = 1'b1;
        end
    endtask

    task automatic send_key(input logic [`CALC_KEY_WIDTH-1:0] code);
        wait_ready(1'b0);
        if (!timed_out) begin
            @(posedge clk);
            key_valid <= 1'b1;
            key_code  <= code;
            @(posedge clk);
            key_valid <= 1'b0;
        end
    endtask

    // Optional stall of 1 to 20 cycles before the result is taken
    task automatic take_result(input bit hold, input logic [31:0] exp_val);
        int cycles;
        cycles = hold ? int'($urandom % 20) + 1 : 0;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_value("result", result, exp_val);
            check_value("key_ready", key_ready, 0);
            check_value("result_valid", result_valid, 1);
        end
        @(posedge clk);
        result_ready <= 1'b1;
        @(posedge clk);
        result_ready <= 1'b0;
    endtask

    task automatic report_test(input string name);
        if (timed_out) begin
            $display("%s: stopped by a timeout", name);
            fail_count++;
        end else if (error_count == errs_before) begin
            $display("%s: ok", name);
            pass_count++;
        end else begin
            $display("%s: %0d mismatches", name, error_count - errs_before);
            fail_count++;
        end
    endtask

    task automatic run_test(input int idx);
        string keys;
        keys        = vec_keys[idx];
        errs_before = error_count;
        for (int k = 0; (k < keys.len()) && !timed_out; k++) begin
            send_key(key_of(keys[k]));
        end
        if (!timed_out) begin
            wait_ready(1'b1);
        end
        if (!timed_out) begin
            check_value("result", result, vec_exp[idx]);
            take_result(vec_hold[idx], vec_exp[idx]);
        end
        report_test(vec_name[idx]);
    endtask

    initial begin
        clk          = 1'b0;
        nRST         = 1'b0;
        key_valid    = 1'b0;
        key_code     = '0;
        result_ready = 1'b0;
        error_count  = 0;
        pass_count   = 0;
        fail_count   = 0;
        timed_out    = 1'b0;
        seed         = 91;
        // Seed the generator once
        rnd          = $urandom(seed);
        load_vectors();

        repeat (2) @(posedge clk);
        nRST <= 1'b1;

        // Idle outputs before any key
        @(negedge clk);
        errs_before = error_count;
        check_value("key_ready", key_ready, 1);
        check_value("result_valid", result_valid, 0);
        report_test("reset_state");

        for (int i = 0; (i < vec_name.size()) && !timed_out; i++) begin
            run_test(i);
        end

        $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
        if ((fail_count == 0) && (error_count == 0) && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+common
+incdir+testbench
common/calc_pkg.sv
common/arith_if.sv
arith/step_counter.sv
arith/add_sub_unit.sv
arith/shift_add_multiplier.sv
verilog/operand_entry.sv
verilog/calc_fsm.sv
verilog/calc_top.sv
testbench/calc_tb.sv
